//--- Makefile
# RD50C controller simulation with Verilator
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_dw
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail, not the simulator's exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
logic/dw_pkg.sv
logic/dw_bus_regs.sv
logic/dw_cmd_seq.sv
logic/dw_sector_buf.sv
logic/dw_irq.sv
logic/dw_top.sv
sim/tb_clkgen.sv
sim/tb_dw.sv

//--- logic/dw_bus_regs.sv
/*
 * RD50C host side: wishbone decode and ack, the CHS, ide and command
 * registers, the status read mux and the software reset request
 */
module dw_bus_regs (
   input  logic                         wb_clk_i,
   input  logic                         wb_rst_i,
   input  logic [dw_pkg::DW_ADR_W-1:0]  wb_adr_i,
   input  logic [dw_pkg::DW_DATA_W-1:0] wb_dat_i,
   output logic [dw_pkg::DW_DATA_W-1:0] wb_dat_o,
   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_we_i,
   input  logic [1:0]                   wb_sel_i,
   output logic                         wb_ack_o,
   input  logic                         rqa_i,       // operation done
   input  logic                         drq_i,       // buffer ready
   input  logic                         busy_i,
   input  logic                         cmderr_i,
   input  logic                         wr_err_i,
   input  logic [dw_pkg::DW_DATA_W-1:0] buf_rdat_i,
   output logic                         cmd_wr_o,    // pulse
   output logic [7:0]                   cmd_code_o,
   output logic                         stat_clr_o,  // pulse, clears rqa
   output logic                         buf_rd_o,    // pulse per DWBUF read
   output logic                         buf_wr_o,    // pulse per DWBUF write
   output logic [dw_pkg::DW_DATA_W-1:0] buf_wdat_o,
   output dw_pkg::dw_chs_u              chs_o,
   output logic                         ide_o,
   output logic                         soft_rst_o
);
   import dw_pkg::*;

   logic [3:0]           reg_sel;   // word offset
   logic                 reply;     // new cycle, ack not yet given
   logic                 rd_req;
   logic                 wr_req;
   logic [DW_DATA_W-1:0] rd_word;

   assign reg_sel = wb_adr_i[DW_ADR_W-1:1];   // byte address, bit 0 ignored
   assign reply   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign rd_req  = reply & ~wb_we_i;
   assign wr_req  = reply & wb_we_i & (wb_sel_i == 2'b11);   // whole words only

   // ack one cycle after strobe, low again the next
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= reply;
      end
   end

   // **************************************************
   // read mux, DVK bit layout
   // **************************************************
   always_comb begin
      case (reg_sel)
         DW_REG_ID:   rd_word = DW_ID_VAL;
         DW_REG_ERR:  rd_word = {5'b0, cmderr_i, 10'b0};
         DW_REG_SEC:  rd_word = DW_DATA_W'(chs_o.fld.sec);
         DW_REG_BUF:  rd_word = buf_rdat_i;
         DW_REG_CYL:  rd_word = DW_DATA_W'(chs_o.fld.cyl);
         DW_REG_HD:   rd_word = DW_DATA_W'(chs_o.fld.hd);
         // drive ready, write error, seek done, drq, error
         DW_REG_CS2:  rd_word = {1'b0, ~busy_i, wr_err_i, ~busy_i, drq_i, 2'b0, cmderr_i, 8'b0};
         // busy, buffer ready (always), ide, done
         DW_REG_STRS: rd_word = {busy_i, 7'b0, 1'b1, ide_o, 5'b0, rqa_i};
         default:     rd_word = '0;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (rd_req) wb_dat_o <= rd_word;      // valid with ack
      if (wr_req) buf_wdat_o <= wb_dat_i;   // goes with buf_wr_o
   end

   // **************************************************
   // host registers and strobes
   // **************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cmd_wr_o   <= 1'b0;
         cmd_code_o <= '0;
         stat_clr_o <= 1'b0;
         buf_rd_o   <= 1'b0;
         buf_wr_o   <= 1'b0;
         chs_o      <= '0;
         ide_o      <= 1'b0;
         soft_rst_o <= 1'b0;
      end else begin
         cmd_wr_o   <= 1'b0;   // strobes default low
         stat_clr_o <= 1'b0;
         buf_rd_o   <= 1'b0;
         buf_wr_o   <= 1'b0;
         soft_rst_o <= 1'b0;
         if (soft_rst_o) begin
            cmd_code_o <= '0;
            chs_o      <= '0;
            ide_o      <= 1'b0;
         end else if (rd_req) begin
            stat_clr_o <= (reg_sel == DW_REG_SEC) || (reg_sel == DW_REG_CS2);
            buf_rd_o   <= (reg_sel == DW_REG_BUF);
         end else if (wr_req) begin
            case (reg_sel)
               DW_REG_SEC: begin
                  chs_o.fld.sec <= wb_dat_i[DW_SEC_W-1:0] - 1'b1;   // sectors count from 1
                  stat_clr_o    <= 1'b1;
               end
               DW_REG_BUF: buf_wr_o <= 1'b1;
               DW_REG_CYL: chs_o.fld.cyl <= wb_dat_i[DW_CYL_W-1:0];
               DW_REG_HD:  chs_o.fld.hd <= wb_dat_i[DW_HD_W-1:0];
               DW_REG_CS2: begin
                  cmd_code_o <= wb_dat_i[7:0];
                  cmd_wr_o   <= 1'b1;
               end
               DW_REG_STRS: begin
                  ide_o      <= wb_dat_i[6];
                  soft_rst_o <= wb_dat_i[3];   // one cycle, clears everything
               end
               default: ;
            endcase
         end
      end
   end

endmodule

//--- logic/dw_cmd_seq.sv
/*
 * RD50C command sequencer: runs recalibrate, read and write, keeps the
 * status flags and does the request/start/done handshake with storage
 */
module dw_cmd_seq (
   input  logic                         wb_clk_i,
   input  logic                         wb_rst_i,
   input  logic                         cmd_wr_i,
   input  logic [7:0]                   cmd_code_i,
   input  logic                         stat_clr_i,
   input  logic                         host_last_i,   // host hit word 255
   input  dw_pkg::dw_chs_u              chs_i,
   input  logic [dw_pkg::DW_BLK_W-1:0]  start_offset_i,
   input  logic                         sd_ack_i,      // medium granted
   input  logic                         sto_idle_i,
   input  logic                         xfer_done_i,
   input  logic                         xfer_err_i,
   input  logic                         soft_rst_i,
   output logic                         rqa_o,
   output logic                         drq_o,
   output logic                         busy_o,
   output logic                         cmderr_o,
   output logic                         wr_err_o,
   output logic                         buf_clr_o,     // pulse, counter to 0
   output logic                         sd_req_o,
   output logic [dw_pkg::DW_BLK_W-1:0]  blk_addr_o,
   output logic                         rd_start_o,
   output logic                         wr_start_o,
   output logic                         done_ack_o
);
   import dw_pkg::*;

   typedef enum logic [2:0] {
      s_idle,   // waiting for a command
      s_fill,   // write, host filling buffer
      s_req,    // medium requested
      s_xfer,   // start level up, waiting done
      s_ack     // done acked, waiting done low
   } seq_state_t;

   seq_state_t state;
   logic       op_wr;   // 1 = write transfer
   logic       err_q;   // engine error seen with done

   assign busy_o = (state == s_req) || (state == s_xfer) || (state == s_ack);

   // disk block = bank base + packed cyl/hd/sec
   assign blk_addr_o = start_offset_i + DW_BLK_W'(chs_i.blk);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state      <= s_idle;
         op_wr      <= 1'b0;
         err_q      <= 1'b0;
         rqa_o      <= 1'b1;   // ready after reset
         drq_o      <= 1'b0;
         cmderr_o   <= 1'b0;
         wr_err_o   <= 1'b0;
         buf_clr_o  <= 1'b0;
         sd_req_o   <= 1'b0;
         rd_start_o <= 1'b0;
         wr_start_o <= 1'b0;
         done_ack_o <= 1'b0;
      end else if (soft_rst_i) begin
         state      <= s_idle;
         op_wr      <= 1'b0;
         err_q      <= 1'b0;
         rqa_o      <= 1'b1;
         drq_o      <= 1'b0;
         cmderr_o   <= 1'b0;
         wr_err_o   <= 1'b0;
         buf_clr_o  <= 1'b0;
         sd_req_o   <= 1'b0;
         rd_start_o <= 1'b0;
         wr_start_o <= 1'b0;
         done_ack_o <= 1'b0;
      end else begin
         buf_clr_o <= 1'b0;
         if (stat_clr_i) rqa_o <= 1'b0;   // host read SEC/CS2 or wrote SEC
         case (state)
            s_idle: begin
               if (host_last_i && drq_o) begin   // read data all taken
                  drq_o <= 1'b0;
                  rqa_o <= 1'b1;
               end
               if (cmd_wr_i) begin
                  rqa_o    <= 1'b0;
                  drq_o    <= 1'b0;
                  cmderr_o <= 1'b0;
                  case (cmd_code_i)
                     DW_CMD_RECAL: rqa_o <= 1'b1;   // nothing to seek
                     DW_CMD_READ: begin
                        op_wr <= 1'b0;
                        state <= s_req;
                     end
                     DW_CMD_WRITE: begin
                        op_wr     <= 1'b1;
                        buf_clr_o <= 1'b1;
                        drq_o     <= 1'b1;   // host may fill buffer
                        state     <= s_fill;
                     end
                     default: cmderr_o <= 1'b1;   // unknown command
                  endcase
               end
            end
            s_fill:
               if (host_last_i) begin
                  drq_o <= 1'b0;
                  state <= s_req;
               end
            s_req: begin
               sd_req_o <= 1'b1;
               if (sd_req_o && sd_ack_i && sto_idle_i) begin   // granted and engine free
                  rd_start_o <= ~op_wr;
                  wr_start_o <= op_wr;
                  state      <= s_xfer;
               end
            end
            s_xfer:
               if (xfer_done_i) begin
                  done_ack_o <= 1'b1;
                  err_q      <= xfer_err_i;
                  state      <= s_ack;
               end
            s_ack:
               if (!xfer_done_i) begin   // engine saw the ack, release all
                  done_ack_o <= 1'b0;
                  rd_start_o <= 1'b0;
                  wr_start_o <= 1'b0;
                  sd_req_o   <= 1'b0;
                  state      <= s_idle;
                  if (op_wr) begin
                     rqa_o <= 1'b1;
                     if (err_q) wr_err_o <= 1'b1;
                  end else if (err_q) begin
                     cmderr_o <= 1'b1;
                  end else begin
                     buf_clr_o <= 1'b1;   // host reads from word 0
                     drq_o     <= 1'b1;
                  end
               end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

//--- logic/dw_irq.sv
/*
 * RD50C interrupt request: raises irq on done or data request while
 * enabled, drops it on acknowledge and waits for the ack to go away
 */
module dw_irq (
   input  logic wb_clk_i,
   input  logic wb_rst_i,
   input  logic ide_i,
   input  logic rqa_i,
   input  logic drq_i,
   input  logic iack_i,
   input  logic soft_rst_i,
   output logic irq_o
);

   typedef enum logic [1:0] {
      i_idle,   // no request pending
      i_req,    // irq up, waiting for iack
      i_wait    // acked, waiting for iack low
   } irq_state_t;

   irq_state_t state;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state <= i_idle;
         irq_o <= 1'b0;
      end else if (soft_rst_i) begin
         state <= i_idle;
         irq_o <= 1'b0;
      end else begin
         case (state)
            i_idle:
               if (ide_i && (rqa_i || drq_i)) begin
                  irq_o <= 1'b1;
                  state <= i_req;
               end
            i_req:
               if (!ide_i) begin   // interrupts disabled meanwhile
                  irq_o <= 1'b0;
                  state <= i_idle;
               end else if (iack_i) begin
                  irq_o <= 1'b0;
                  state <= i_wait;
               end
            i_wait:
               if (!iack_i) state <= i_idle;
            default: state <= i_idle;
         endcase
      end
   end

endmodule

//--- logic/dw_pkg.sv
/*
 * RD50C disk controller (DVK style) shared definitions:
 * register offsets, command codes, field widths and the CHS word
 */
package dw_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int DW_DATA_W = 16;   // bus word
   localparam int DW_ADR_W  = 5;    // wishbone byte address
   localparam int DW_BLK_W  = 23;   // storage block address
   localparam int DW_BUF_AW = 8;    // 256 word sector buffer

   localparam int DW_CYL_W = 10;    // 1024 cylinders
   localparam int DW_HD_W  = 3;     // 8 heads
   localparam int DW_SEC_W = 4;     // 16 sectors per track

   // **************************************************
   // register word offsets
   // **************************************************
   localparam logic [3:0] DW_REG_ID   = 4'd0;   // identification, r/o
   localparam logic [3:0] DW_REG_ERR  = 4'd1;   // error flags
   localparam logic [3:0] DW_REG_SEC  = 4'd3;   // sector number
   localparam logic [3:0] DW_REG_BUF  = 4'd4;   // data buffer window
   localparam logic [3:0] DW_REG_CYL  = 4'd5;   // cylinder
   localparam logic [3:0] DW_REG_HD   = 4'd6;   // head
   localparam logic [3:0] DW_REG_CS2  = 4'd7;   // command / status 2
   localparam logic [3:0] DW_REG_STRS = 4'd8;   // status / reset

   localparam logic [DW_DATA_W-1:0] DW_ID_VAL = 16'o401;

   // command codes written to CS2
   localparam logic [7:0] DW_CMD_RECAL = 8'o20;   // seek cyl 0, no-op here
   localparam logic [7:0] DW_CMD_READ  = 8'o40;
   localparam logic [7:0] DW_CMD_WRITE = 8'o60;

   // **************************************************
   // chs word, 17 bits
   // **************************************************
   typedef struct packed {
      logic [DW_CYL_W-1:0] cyl;
      logic [DW_HD_W-1:0]  hd;
      logic [DW_SEC_W-1:0] sec;   // already minus one
   } dw_chs_s;

   // register side fills fields, sequencer reads blk
   typedef union packed {
      dw_chs_s                               fld;
      logic [DW_CYL_W+DW_HD_W+DW_SEC_W-1:0] blk;
   } dw_chs_u;

endpackage

//--- logic/dw_sector_buf.sv
/*
 * RD50C sector buffer, 256 x 16, two ports: host port addressed by
 * an auto-increment word counter, storage engine port addressed directly
 */
module dw_sector_buf (
   input  logic                          wb_clk_i,
   input  logic                          wb_rst_i,
   input  logic                          buf_clr_i,
   input  logic                          buf_rd_i,
   input  logic                          buf_wr_i,
   input  logic [dw_pkg::DW_DATA_W-1:0]  buf_wdat_i,
   input  logic [dw_pkg::DW_BUF_AW-1:0]  stor_addr_i,
   input  logic                          stor_we_i,
   input  logic [dw_pkg::DW_DATA_W-1:0]  stor_wdat_i,
   input  logic                          soft_rst_i,
   output logic [dw_pkg::DW_DATA_W-1:0]  host_rdat_o,
   output logic                          host_last_o,
   output logic [dw_pkg::DW_DATA_W-1:0]  stor_rdat_o
);
   import dw_pkg::*;

   logic [DW_DATA_W-1:0] mem [2**DW_BUF_AW];
   logic [DW_BUF_AW-1:0] host_cnt;    // next host word
   logic                 host_step;   // any DWBUF access

   assign host_step = buf_rd_i | buf_wr_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         host_cnt <= '0;
      end else if (soft_rst_i || buf_clr_i) begin
         host_cnt <= '0;
      end else if (host_step) begin
         host_cnt <= host_cnt + 1'b1;   // wraps to 0 after word 255
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (buf_wr_i) mem[host_cnt] <= buf_wdat_i;
      if (stor_we_i) mem[stor_addr_i] <= stor_wdat_i;   // engine filling on read
   end

   assign host_rdat_o = mem[host_cnt];
   assign stor_rdat_o = mem[stor_addr_i];
   assign host_last_o = host_step & (&host_cnt);   // access on last word
endmodule

//--- logic/dw_top.sv
/*
 * RD50C hard disk controller, DVK variant, wishbone slave with a
 * storage engine port and a direct port into the sector buffer
 */
module dw_top (
   input  logic                         wb_clk_i,
   input  logic                         wb_rst_i,
   input  logic [dw_pkg::DW_ADR_W-1:0]  wb_adr_i,
   input  logic [dw_pkg::DW_DATA_W-1:0] wb_dat_i,
   output logic [dw_pkg::DW_DATA_W-1:0] wb_dat_o,
   input  logic                         wb_cyc_i,
   input  logic                         wb_stb_i,
   input  logic                         wb_we_i,
   input  logic [1:0]                   wb_sel_i,
   output logic                         wb_ack_o,
   output logic                         irq_o,
   input  logic                         iack_i,
   output logic                         sd_req_o,       // medium request
   input  logic                         sd_ack_i,       // medium grant
   input  logic                         sto_idle_i,
   input  logic                         xfer_done_i,
   input  logic                         xfer_err_i,
   input  logic [dw_pkg::DW_BLK_W-1:0]  start_offset_i, // bank base
   output logic [dw_pkg::DW_BLK_W-1:0]  blk_addr_o,
   output logic                         rd_start_o,
   output logic                         wr_start_o,
   output logic                         done_ack_o,
   input  logic [dw_pkg::DW_BUF_AW-1:0] stor_addr_i,
   input  logic                         stor_we_i,
   input  logic [dw_pkg::DW_DATA_W-1:0] stor_wdat_i,
   output logic [dw_pkg::DW_DATA_W-1:0] stor_rdat_o
);
   import dw_pkg::*;

   logic                 cmd_wr;
   logic [7:0]           cmd_code;
   logic                 stat_clr;
   logic                 buf_rd;
   logic                 buf_wr;
   logic [DW_DATA_W-1:0] buf_wdat;
   logic [DW_DATA_W-1:0] host_rdat;
   logic                 host_last;
   logic                 buf_clr;
   dw_chs_u              chs;
   logic                 ide;
   logic                 soft_rst;
   logic                 rqa;
   logic                 drq;
   logic                 busy;
   logic                 cmderr;
   logic                 wr_err;

   dw_bus_regs bus_regs_i (
      .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_cyc_i,
      .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_ack_o,
      .rqa_i(rqa), .drq_i(drq), .busy_i(busy), .cmderr_i(cmderr), .wr_err_i(wr_err),
      .buf_rdat_i(host_rdat), .cmd_wr_o(cmd_wr), .cmd_code_o(cmd_code),
      .stat_clr_o(stat_clr), .buf_rd_o(buf_rd), .buf_wr_o(buf_wr),
      .buf_wdat_o(buf_wdat), .chs_o(chs), .ide_o(ide), .soft_rst_o(soft_rst)
   );

   dw_cmd_seq cmd_seq_i (
      .wb_clk_i, .wb_rst_i, .cmd_wr_i(cmd_wr), .cmd_code_i(cmd_code),
      .stat_clr_i(stat_clr), .host_last_i(host_last), .chs_i(chs), .start_offset_i,
      .sd_ack_i, .sto_idle_i, .xfer_done_i, .xfer_err_i, .soft_rst_i(soft_rst),
      .rqa_o(rqa), .drq_o(drq), .busy_o(busy), .cmderr_o(cmderr), .wr_err_o(wr_err),
      .buf_clr_o(buf_clr), .sd_req_o, .blk_addr_o, .rd_start_o, .wr_start_o, .done_ack_o
   );

   dw_sector_buf sector_buf_i (
      .wb_clk_i, .wb_rst_i, .buf_clr_i(buf_clr), .buf_rd_i(buf_rd), .buf_wr_i(buf_wr),
      .buf_wdat_i(buf_wdat), .stor_addr_i, .stor_we_i, .stor_wdat_i,
      .soft_rst_i(soft_rst), .host_rdat_o(host_rdat), .host_last_o(host_last), .stor_rdat_o
   );

   dw_irq irq_i (
      .wb_clk_i, .wb_rst_i, .ide_i(ide), .rqa_i(rqa), .drq_i(drq), .iack_i,
      .soft_rst_i(soft_rst), .irq_o
   );

endmodule

//--- sim/tb_clkgen.sv
/*
 * testbench clock and reset: 10 ns clock, reset held for 4 cycles
 */
module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;   // 10 ns period
   end

   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);   // release away from the active edge
      rst_o = 1'b0;
   end
endmodule

//--- sim/tb_dw.sv
/*
 * RD50C controller testbench: wishbone bus tasks, storage engine model,
 * reference pattern, queued compare process and a watchdog
 */
module tb_dw;
   timeunit 1ns;
   timeprecision 100ps;
   import dw_pkg::*;

   localparam int WD_CYCLES = 256 * 4 * 40;   // words x transfers x cycles

   logic        wb_clk_i, wb_rst_i;
   logic [4:0]  wb_adr_i;
   logic [15:0] wb_dat_i, wb_dat_o;
   logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [1:0]  wb_sel_i;
   logic        irq_o, iack_i;
   logic        sd_req_o, sd_ack_i, sto_idle_i, xfer_done_i, xfer_err_i;
   logic [22:0] start_offset_i, blk_addr_o;
   logic        rd_start_o, wr_start_o, done_ack_o;
   logic [7:0]  stor_addr_i;
   logic        stor_we_i;
   logic [15:0] stor_wdat_i, stor_rdat_o;

   int          seed = 47;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   logic        inject_err = 1'b0;      // engine reports error with done
   logic [15:0] disk [logic [30:0]];    // {block, word} -> data
   logic [15:0] exp_buf [256];          // expected sector contents
   string       q_name[$];
   logic [31:0] q_got[$];
   logic [31:0] q_want[$];

   tb_clkgen clkgen_i (.clk_o(wb_clk_i), .rst_o(wb_rst_i));
   dw_top dw_top_i (.*);

   // preload pattern mixing every block and word address bit
   function automatic logic [15:0] ref_word(logic [22:0] blk, logic [7:0] idx);
      logic [15:0] mix;
      mix = blk[15:0] ^ {blk[22:16], 9'b0} ^ {idx, ~idx};
      return (mix * 16'h9e37) ^ {8'h5a, idx};
   endfunction

   function automatic logic [15:0] disk_word(logic [22:0] blk, logic [7:0] idx);
      if (disk.exists({blk, idx})) return disk[{blk, idx}];
      return ref_word(blk, idx);   // never written
   endfunction

   task automatic expect_val(string name, logic [31:0] got, logic [31:0] want);
      q_name.push_back(name);
      q_got.push_back(got);
      q_want.push_back(want);
   endtask

   // **************************************************
   // compare and watchdog
   // **************************************************
   always @(posedge wb_clk_i) begin : compare
      string       nm;
      logic [31:0] got;
      logic [31:0] want;
      while (q_name.size() > 0) begin
         nm   = q_name.pop_front();
         got  = q_got.pop_front();
         want = q_want.pop_front();
         chk_cnt++;
         assert (got === want) else begin
            err_cnt++;
            $display("Fail %s: got 0x%h, expected 0x%h", nm, got, want);
         end
      end
   end

   initial begin : watchdog
      repeat (WD_CYCLES) @(posedge wb_clk_i);
      $display("timeout: test still running after %0d cycles", WD_CYCLES);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt + 1);
      $display("SIMULATION FAILED");
      $finish;
   end

   // **************************************************
   // storage engine model
   // **************************************************
   initial begin : storage_model
      logic [22:0] blk;
      sd_ack_i    = 1'b0;
      sto_idle_i  = 1'b1;
      xfer_done_i = 1'b0;
      xfer_err_i  = 1'b0;
      stor_addr_i = '0;
      stor_we_i   = 1'b0;
      stor_wdat_i = '0;
      forever begin
         @(negedge wb_clk_i);
         sd_ack_i = sd_req_o;   // grant whenever asked
         if (rd_start_o || wr_start_o) begin
            blk        = blk_addr_o;
            expect_val("sd_req_o", sd_req_o, 1);   // start only with the medium held
            sto_idle_i = 1'b0;
            for (int i = 0; i < 256; i++) begin
               stor_addr_i = i[7:0];
               if (rd_start_o) begin   // fill buffer from disk
                  stor_wdat_i = disk_word(blk, i[7:0]);
                  stor_we_i   = 1'b1;
                  @(negedge wb_clk_i);
               end else begin
                  @(posedge wb_clk_i);
                  if (!inject_err) disk[{blk, i[7:0]}] = stor_rdat_o;
                  @(negedge wb_clk_i);
               end
            end
            stor_we_i   = 1'b0;
            xfer_err_i  = inject_err;
            xfer_done_i = 1'b1;
            while (!done_ack_o) @(negedge wb_clk_i);
            xfer_done_i = 1'b0;   // sequencer drops start once done is low
            xfer_err_i  = 1'b0;
            while (rd_start_o || wr_start_o) @(negedge wb_clk_i);
            sto_idle_i = 1'b1;
         end
      end
   end

   // **************************************************
   // bus tasks
   // **************************************************
   task automatic bus_access(input logic we, input logic [3:0] off, input logic [15:0] wdat,
                             output logic [15:0] rdat);
      int n;
      @(negedge wb_clk_i);
      wb_adr_i = {off, 1'b0};   // word offset to byte address
      wb_dat_i = wdat;
      wb_we_i  = we;
      wb_sel_i = 2'b11;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      n = 0;
      do begin
         @(negedge wb_clk_i);
         n++;
      end while (!wb_ack_o && n < 16);
      assert (wb_ack_o) else begin
         err_cnt++;
         $display("no ack from register offset %0d within 16 cycles", off);
      end
      rdat     = wb_dat_o;   // valid with ack
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic reg_write(input logic [3:0] off, input logic [15:0] val);
      logic [15:0] unused;
      bus_access(1'b1, off, val, unused);
   endtask

   task automatic reg_read(input logic [3:0] off, output logic [15:0] val);
      bus_access(1'b0, off, 16'h0000, val);
   endtask

   // poll a status bit until it sets
   task automatic wait_bit(input logic [3:0] off, input int bit_no, input string what);
      logic [15:0] v;
      int          n;
      n = 0;
      do begin
         reg_read(off, v);
         n++;
      end while (!v[bit_no] && n < 1000);
      assert (v[bit_no]) else begin
         err_cnt++;
         $display("%s never arrived", what);
      end
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while (irq_o !== level && n < 20) begin
         @(negedge wb_clk_i);
         n++;
      end
      expect_val("irq_o", irq_o, level);
   endtask

   // random cyl/hd/sector with readback and the expected block address
   task automatic set_chs(output logic [22:0] blk);
      logic [31:0] rnd;
      logic [15:0] v;
      rnd = $random(seed);
      reg_write(DW_REG_CYL, {6'b0, rnd[9:0]});
      reg_write(DW_REG_HD, {13'b0, rnd[12:10]});
      reg_write(DW_REG_SEC, {12'b0, rnd[16:13]} + 16'd1);   // sector 1..16
      reg_read(DW_REG_SEC, v);
      expect_val("SEC", v, {12'b0, rnd[16:13]});
      reg_read(DW_REG_CYL, v);
      expect_val("CYL", v, {6'b0, rnd[9:0]});
      reg_read(DW_REG_HD, v);
      expect_val("HD", v, {13'b0, rnd[12:10]});
      blk = start_offset_i + {6'b0, rnd[9:0], rnd[12:10], rnd[16:13]};
   endtask

   task automatic read_block(input logic [22:0] blk);
      logic [15:0] v;
      reg_write(DW_REG_CS2, {8'b0, DW_CMD_READ});
      expect_val("blk_addr_o", blk_addr_o, blk);
      wait_bit(DW_REG_CS2, 11, "read data request");
      for (int i = 0; i < 256; i++) begin
         reg_read(DW_REG_BUF, v);
         expect_val($sformatf("DWBUF[%0d]", i), v, exp_buf[i]);
      end
      reg_read(DW_REG_STRS, v);   // before CS2 as that read clears done
      expect_val("STRS bit 0", v[0], 1);
      reg_read(DW_REG_CS2, v);
      expect_val("CS2 bit 11", v[11], 0);
   endtask

   task automatic write_block(input logic err);
      logic [15:0] v;
      inject_err = err;
      reg_write(DW_REG_CS2, {8'b0, DW_CMD_WRITE});
      wait_bit(DW_REG_CS2, 11, "write data request");
      for (int i = 0; i < 256; i++) reg_write(DW_REG_BUF, exp_buf[i]);
      wait_bit(DW_REG_STRS, 0, "write completion");
      reg_read(DW_REG_CS2, v);
      expect_val("CS2 bit 13", v[13], err);
      inject_err = 1'b0;
   endtask

   // **************************************************
   // test sequence
   // **************************************************
   initial begin : main
      logic [15:0] v;
      logic [22:0] blk;
      wb_adr_i       = '0;
      wb_dat_i       = '0;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      wb_we_i        = 1'b0;
      wb_sel_i       = '0;
      iack_i         = 1'b0;
      start_offset_i = 23'($random(seed));   // bank base
      wait (wb_rst_i === 1'b1);
      wait (wb_rst_i === 1'b0);

      reg_read(DW_REG_ID, v);
      expect_val("ID", v, 16'o401);
      reg_read(DW_REG_STRS, v);
      expect_val("STRS", v, 16'h0081);
      expect_val("irq_o", irq_o, 0);
      expect_val("sd_req_o", sd_req_o, 0);
      expect_val("rd_start_o", rd_start_o, 0);
      expect_val("wr_start_o", wr_start_o, 0);
      expect_val("done_ack_o", done_ack_o, 0);

      set_chs(blk);   // untouched block reads the preload pattern
      for (int i = 0; i < 256; i++) exp_buf[i] = ref_word(blk, i[7:0]);
      read_block(blk);

      set_chs(blk);
      for (int i = 0; i < 256; i++) exp_buf[i] = 16'($random(seed));
      write_block(1'b0);
      for (int i = 0; i < 256; i++) expect_val("stored word", disk_word(blk, i[7:0]), exp_buf[i]);
      read_block(blk);   // read back what was written
      write_block(1'b1);   // engine error ends in write_error

      // interrupt sequencing
      reg_read(DW_REG_SEC, v);   // clears done
      reg_write(DW_REG_STRS, 16'h0040);
      repeat (3) @(negedge wb_clk_i);
      expect_val("irq_o", irq_o, 0);
      reg_write(DW_REG_CS2, {8'b0, DW_CMD_RECAL});
      wait_irq(1'b1);
      iack_i = 1'b1;
      wait_irq(1'b0);
      reg_read(DW_REG_SEC, v);
      reg_write(DW_REG_CS2, {8'b0, DW_CMD_RECAL});   // new event while iack held
      repeat (4) @(negedge wb_clk_i);
      expect_val("irq_o", irq_o, 0);
      iack_i = 1'b0;
      wait_irq(1'b1);
      reg_write(DW_REG_STRS, 16'h0000);   // ide off drops the request
      wait_irq(1'b0);

      // unknown command, then soft reset
      reg_write(DW_REG_CS2, 16'o70);
      reg_read(DW_REG_ERR, v);
      expect_val("ERR", v, 16'h0400);
      reg_read(DW_REG_CS2, v);
      expect_val("CS2 bit 8", v[8], 1);
      reg_write(DW_REG_STRS, 16'h0008);
      reg_read(DW_REG_ID, v);
      expect_val("ID", v, 16'o401);
      reg_read(DW_REG_STRS, v);
      expect_val("STRS", v, 16'h0081);
      reg_read(DW_REG_ERR, v);
      expect_val("ERR", v, 16'h0000);
      reg_read(DW_REG_CS2, v);
      expect_val("CS2", v, 16'h5000);   // ready and seek done only
      expect_val("irq_o", irq_o, 0);

      repeat (2) @(posedge wb_clk_i);   // let the compare queue drain
      @(negedge wb_clk_i);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end
endmodule
